// ==== list.f ====
+incdir+include
design/aes_pkg.sv
design/aes_key_expand.sv
design/aes_inv_round.sv
design/aes_decrypt_segment.sv
design/aes_decrypt.sv
sim/aes_decrypt_tb.sv

// ==== sim/aes_decrypt_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_decrypt_tb
  import aes_pkg::*;
;

  // FIPS-197 appendix C.1 vector
  localparam logic [STATE_W-1:0] KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [STATE_W-1:0] CT_A = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam logic [STATE_W-1:0] PT_A = 128'h00112233445566778899aabbccddeeff;
  // FIPS-197 appendix B vector
  localparam logic [STATE_W-1:0] KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [STATE_W-1:0] CT_B = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam logic [STATE_W-1:0] PT_B = 128'h3243f6a8885a308d313198a2e0370734;

  logic clk;
  logic reset;
  logic valid_in;
  logic [STATE_W-1:0] ciphertext;
  logic [STATE_W-1:0] key;
  wire valid_out;
  wire [STATE_W-1:0] plaintext;

  logic [STATE_W-1:0] exp_q [$];
  logic [STATE_W-1:0] exp_head;
  int errors;
  int timeouts;
  int tests;
  int checked;
  int fail_mark;
  int seed;

  aes_decrypt aes_decrypt_i (
    .clk(clk),
    .reset(reset),
    .valid_in(valid_in),
    .ciphertext(ciphertext),
    .key(key),
    .valid_out(valid_out),
    .plaintext(plaintext)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Expected value for the output that the next rising edge samples
  always @(negedge clk) begin
    if (!reset && valid_out) begin
      if (exp_q.size() == 0) begin
        $display("Output block appeared at %0t with no block expected", $time);
        errors = errors + 1;
      end else begin
        exp_head = exp_q.pop_front();
        checked = checked + 1;
      end
    end
  end

  a_latency: assert property (@(posedge clk) disable iff (reset)
    !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3) && !$past(reset, 4)
      |-> valid_out == $past(valid_in, 4))
    else begin
      $display("** Error at %0t: valid_out %b does not match valid_in four cycles earlier",
               $time, $sampled(valid_out));
      errors = errors + 1;
    end

  a_plaintext: assert property (@(posedge clk) disable iff (reset)
    valid_out |-> plaintext == exp_head)
    else begin
      $display("** Error at %0t: plaintext %h, expected %h",
               $time, $sampled(plaintext), exp_head);
      errors = errors + 1;
    end

  a_quiet_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !valid_out [*4])
    else begin
      $display("** Error at %0t: valid_out high within four cycles after reset", $time);
      errors = errors + 1;
    end

  task automatic apply_reset(input int cycles);
    @(negedge clk);
    valid_in = 1'b0;
    reset = 1'b1;
    exp_q.delete();
    repeat (cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic send_block(input bit use_b);
    @(negedge clk);
    valid_in = 1'b1;
    ciphertext = use_b ? CT_B : CT_A;
    key = use_b ? KEY_B : KEY_A;
    exp_q.push_back(use_b ? PT_B : PT_A);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      valid_in = 1'b0;
    end
  endtask

  // Returns once every queued block has left the DUT and been compared
  task automatic wait_for_drain(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    valid_in = 1'b0;
    while ((exp_q.size() != 0 || valid_out) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= limit) begin
      $display("Timeout: outputs still pending after %0d cycles", limit);
      timeouts = timeouts + 1;
    end
  endtask

  task automatic end_test(input string name);
    if (errors + timeouts == fail_mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d failures", name, errors + timeouts - fail_mark);
    end
    fail_mark = errors + timeouts;
    tests++;
  endtask

  initial begin
    bit pick;
    int gap;
    reset = 1'b1;
    valid_in = 1'b0;
    ciphertext = '0;
    key = '0;
    exp_head = '0;
    errors = 0;
    timeouts = 0;
    tests = 0;
    checked = 0;
    fail_mark = 0;
    seed = 32'hab064652;

    apply_reset(8);

    // Idle pipeline, then a block dropped by reset mid-flight
    idle_cycles(6);
    send_block(1'b0);
    idle_cycles(1);
    apply_reset(2);
    idle_cycles(8);
    end_test("test 1 reset behavior");

    send_block(1'b0);
    wait_for_drain(20);
    end_test("test 2 known answer A");

    send_block(1'b1);
    wait_for_drain(20);
    end_test("test 3 known answer B");

    for (int i = 0; i < 8; i++) begin
      send_block(i[0]);
    end
    wait_for_drain(30);
    end_test("test 4 back-to-back");

    for (int i = 0; i < 20; i++) begin
      pick = $random(seed) & 1;
      gap = $unsigned($random(seed)) % 4;
      send_block(pick);
      idle_cycles(gap);
    end
    wait_for_drain(30);
    end_test("test 5 random gaps");

    $display("Summary: %0d tests, %0d blocks checked, %0d errors, %0d timeouts",
             tests, checked, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/aes_decrypt.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_decrypt
  import aes_pkg::*;
(
  input  wire clk,
  input  wire reset,
  input  wire valid_in,
  input  wire [STATE_W-1:0] ciphertext,
  input  wire [STATE_W-1:0] key,
  output logic valid_out,
  output logic [STATE_W-1:0] plaintext
);

  localparam int NUM_SEGS = 3;
  // Segment 0 also covers the round 10 key addition
  localparam int SEG_TOP [0:NUM_SEGS-1] = '{NUM_ROUNDS, 6, 3};
  localparam int SEG_COUNT [0:NUM_SEGS-1] = '{4, 3, 3};

  logic seg_valid [0:NUM_SEGS];
  aes_state_u seg_state [0:NUM_SEGS];
  round_keys_t seg_keys [0:NUM_SEGS];

  aes_key_expand aes_key_expand_i (
    .key(key),
    .round_keys(seg_keys[0])
  );

  assign seg_valid[0] = valid_in;
  assign seg_state[0] = ciphertext;

  for (genvar s = 0; s < NUM_SEGS; s++) begin : g_segs
    aes_decrypt_segment #(
      .TOP_ROUND(SEG_TOP[s]),
      .ROUND_COUNT(SEG_COUNT[s])
    ) aes_decrypt_segment_i (
      .clk(clk),
      .reset(reset),
      .valid_in(seg_valid[s]),
      .state_in(seg_state[s]),
      .keys_in(seg_keys[s]),
      .valid_out(seg_valid[s+1]),
      .state_out(seg_state[s+1]),
      .keys_out(seg_keys[s+1])
    );
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      plaintext <= '0;
    end else begin
      valid_out <= seg_valid[NUM_SEGS];
      plaintext <= seg_state[NUM_SEGS];
    end
  end

  // End to end latency through all four register stages
  a_valid_latency: assert property (@(posedge clk) disable iff (reset)
    !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3) && !$past(reset, 4)
      |-> valid_out == $past(valid_in, 4));

endmodule

`default_nettype wire

// ==== design/aes_decrypt_segment.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_decrypt_segment
  import aes_pkg::*;
#(
  parameter int TOP_ROUND = NUM_ROUNDS,
  parameter int ROUND_COUNT = 4
) (
  input  wire clk,
  input  wire reset,
  input  wire valid_in,
  input  var aes_state_u state_in,
  input  var round_keys_t keys_in,
  output logic valid_out,
  output aes_state_u state_out,
  output round_keys_t keys_out
);

  logic valid_q;
  aes_state_u state_q;
  round_keys_t keys_q;
  aes_state_u chain [0:ROUND_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    state_q <= state_in;
    keys_q <= keys_in;
  end

  // Initial AddRoundKey with the last round key
  if (TOP_ROUND == NUM_ROUNDS) begin : g_first
    assign chain[0] = state_q ^ keys_q[NUM_ROUNDS];
  end else begin : g_pass
    assign chain[0] = state_q;
  end

  for (genvar i = 0; i < ROUND_COUNT; i++) begin : g_rounds
    localparam int ROUND = TOP_ROUND - 1 - i;

    aes_inv_round #(
      .FINAL(ROUND == 0)
    ) aes_inv_round_i (
      .state_in(chain[i]),
      .round_key(keys_q[ROUND]),
      .state_out(chain[i+1])
    );
  end

  assign valid_out = valid_q;
  assign state_out = chain[ROUND_COUNT];
  assign keys_out = keys_q;

  a_valid_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(valid_q));

endmodule

`default_nettype wire

// ==== design/aes_inv_round.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_inv_round
  import aes_pkg::*;
#(
  parameter bit FINAL = 1'b0
) (
  input  var aes_state_u state_in,
  input  wire [STATE_W-1:0] round_key,
  output aes_state_u state_out
);

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // One column through the inverse MixColumns matrix
  function automatic logic [WORD_W-1:0] inv_mix_col(input logic [WORD_W-1:0] col);
    logic [0:3][7:0] a;
    logic [0:3][7:0] m9;
    logic [0:3][7:0] m11;
    logic [0:3][7:0] m13;
    logic [0:3][7:0] m14;
    logic [7:0] x2;
    logic [7:0] x4;
    logic [7:0] x8;
    a = col;
    for (int i = 0; i < 4; i++) begin
      x2 = xtime(a[i]);
      x4 = xtime(x2);
      x8 = xtime(x4);
      m9[i] = x8 ^ a[i];
      m11[i] = x8 ^ x2 ^ a[i];
      m13[i] = x8 ^ x4 ^ a[i];
      m14[i] = x8 ^ x4 ^ x2;
    end
    return {m14[0] ^ m11[1] ^ m13[2] ^ m9[3],
            m9[0] ^ m14[1] ^ m11[2] ^ m13[3],
            m13[0] ^ m9[1] ^ m14[2] ^ m11[3],
            m11[0] ^ m13[1] ^ m9[2] ^ m14[3]};
  endfunction

  aes_state_u shifted;
  aes_state_u subbed;
  aes_state_u keyed;

  // Row r rotates right by r columns
  always_comb begin
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[4*c + r] = state_in.bytes[4*((c - r + 4) % 4) + r];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      subbed.bytes[i] = INV_SBOX[shifted.bytes[i]];
    end
  end

  assign keyed = subbed ^ round_key;

  if (FINAL) begin : g_final
    assign state_out = keyed;
  end else begin : g_mix
    always_comb begin
      for (int c = 0; c < NUM_COLS; c++) begin
        state_out.cols[c] = inv_mix_col(keyed.cols[c]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/aes_key_expand.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_key_expand
  import aes_pkg::*;
(
  input  wire [STATE_W-1:0] key,
  output round_keys_t round_keys
);

  localparam int NUM_WORDS = NUM_COLS * (NUM_ROUNDS + 1);

  wire [WORD_W-1:0] w [0:NUM_WORDS-1];

  for (genvar i = 0; i < NUM_COLS; i++) begin : g_key_words
    assign w[i] = key[STATE_W-1-WORD_W*i -: WORD_W];
  end

  for (genvar r = 1; r <= NUM_ROUNDS; r++) begin : g_round
    logic [WORD_W-1:0] rot_word;
    logic [WORD_W-1:0] sub_word;

    assign rot_word = {w[4*r-1][23:0], w[4*r-1][31:24]};
    assign sub_word = {SBOX[rot_word[31:24]], SBOX[rot_word[23:16]],
                       SBOX[rot_word[15:8]], SBOX[rot_word[7:0]]} ^ RCON[r];

    // Each new word chains off the one before it
    assign w[4*r]   = w[4*r-4] ^ sub_word;
    assign w[4*r+1] = w[4*r-3] ^ w[4*r];
    assign w[4*r+2] = w[4*r-2] ^ w[4*r+1];
    assign w[4*r+3] = w[4*r-1] ^ w[4*r+2];
  end

  always_comb begin
    for (int r = 0; r <= NUM_ROUNDS; r++) begin
      round_keys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
  end

endmodule

`default_nettype wire

// ==== design/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

  localparam int STATE_W = 128;
  localparam int WORD_W = 32;
  localparam int NUM_BYTES = 16;
  localparam int NUM_COLS = STATE_W / WORD_W;
  localparam int NUM_ROUNDS = 10;

  // Byte 0 and column 0 are the most significant
  typedef union packed {
    logic [0:NUM_BYTES-1][7:0] bytes;
    logic [0:NUM_COLS-1][WORD_W-1:0] cols;
  } aes_state_u;

  // Indexed by round number
  typedef logic [STATE_W-1:0] round_keys_t [0:NUM_ROUNDS];

  localparam logic [WORD_W-1:0] RCON [0:NUM_ROUNDS] = '{
    32'h00000000,
    32'h01000000,
    32'h02000000,
    32'h04000000,
    32'h08000000,
    32'h10000000,
    32'h20000000,
    32'h40000000,
    32'h80000000,
    32'h1b000000,
    32'h36000000
  };

  `include "aes_sbox_tables.svh"

endpackage

`default_nettype wire

// ==== include/aes_sbox_tables.svh ====
`ifndef AES_SBOX_TABLES_SVH
`define AES_SBOX_TABLES_SVH

// Forward S-box, entry 0 in the leftmost byte
localparam logic [0:255][7:0] SBOX = {
  64'h637c777b_f26b6fc5, 64'h3001672b_fed7ab76,
  64'hca82c97d_fa5947f0, 64'hadd4a2af_9ca472c0,
  64'hb7fd9326_363ff7cc, 64'h34a5e5f1_71d83115,
  64'h04c723c3_1896059a, 64'h071280e2_eb27b275,
  64'h09832c1a_1b6e5aa0, 64'h523bd6b3_29e32f84,
  64'h53d100ed_20fcb15b, 64'h6acbbe39_4a4c58cf,
  64'hd0efaafb_434d3385, 64'h45f9027f_503c9fa8,
  64'h51a3408f_929d38f5, 64'hbcb6da21_10fff3d2,
  64'hcd0c13ec_5f974417, 64'hc4a77e3d_645d1973,
  64'h60814fdc_222a9088, 64'h46eeb814_de5e0bdb,
  64'he0323a0a_4906245c, 64'hc2d3ac62_9195e479,
  64'he7c8376d_8dd54ea9, 64'h6c56f4ea_657aae08,
  64'hba78252e_1ca6b4c6, 64'he8dd741f_4bbd8b8a,
  64'h703eb566_4803f60e, 64'h613557b9_86c11d9e,
  64'he1f89811_69d98e94, 64'h9b1e87e9_ce5528df,
  64'h8ca1890d_bfe64268, 64'h41992d0f_b054bb16
};

// Inverse S-box
localparam logic [0:255][7:0] INV_SBOX = {
  64'h52096ad5_3036a538, 64'hbf40a39e_81f3d7fb,
  64'h7ce33982_9b2fff87, 64'h348e4344_c4dee9cb,
  64'h547b9432_a6c2233d, 64'hee4c950b_42fac34e,
  64'h082ea166_28d924b2, 64'h765ba249_6d8bd125,
  64'h72f8f664_86689816, 64'hd4a45ccc_5d65b692,
  64'h6c704850_fdedb9da, 64'h5e154657_a78d9d84,
  64'h90d8ab00_8cbcd30a, 64'hf7e45805_b8b34506,
  64'hd02c1e8f_ca3f0f02, 64'hc1afbd03_01138a6b,
  64'h3a911141_4f67dcea, 64'h97f2cfce_f0b4e673,
  64'h96ac7422_e7ad3585, 64'he2f937e8_1c75df6e,
  64'h47f11a71_1d29c589, 64'h6fb7620e_aa18be1b,
  64'hfc563e4b_c6d27920, 64'h9adbc0fe_78cd5af4,
  64'h1fdda833_8807c731, 64'hb1121059_2780ec5f,
  64'h60517fa9_19b54a0d, 64'h2de57a9f_93c99cef,
  64'ha0e03b4d_ae2af5b0, 64'hc8ebbb3c_83539961,
  64'h172b047e_ba77d626, 64'he1691463_55210c7d
};

`endif
